/* files.f */
logic/trace_pkg.sv
logic/csr_snapshot.sv
logic/store_tracker.sv
logic/commit_report.sv
logic/perf_counters.sv
logic/commit_tracer.sv
bench/commit_tracer_checker.sv
bench/commit_tracer_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f files.f --top-module commit_tracer_tb \
    -Mdir obj_dir -o tb_sim || exit 1
./obj_dir/tb_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log
grep -q "^TB PASSED$" sim.log && exit 0 || exit 1

/* bench/commit_tracer_tb.sv */
// testbench for the commit tracer that drives decode, commit, CSR, store and event traffic
`timescale 1ns/10ps

module commit_tracer_tb
    import trace_pkg::*;
();

    localparam int rob_bits  = 7;
    localparam int cnt_width = 32;

    logic                                  clk;
    logic                                  rst;
    logic                                  dec_valid;
    logic [rob_bits-1:0]                   dec_opid;
    csr_state_t                            csr_now;
    commit_t                               cmt_in;
    csr_write_t                            csr_wr;
    store_req_t                            st_req;
    store_resp_t                           st_resp;
    logic [num_events-1:0]                 pmd;
    commit_out_t                           cmt_out;
    csr_write_t                            csr_out;
    mem_out_t                              mem_out;
    logic [num_events-1:0][cnt_width-1:0] counts;

    integer      seed = 32'he5b0a85d;
    int          tests_done = 0;
    int          timeouts = 0;
    int          errors;
    logic [rob_bits-1:0] opids [5];
    logic [11:0] csr_list [7];
    logic [7:0]  strb_list [6];

    commit_tracer #(
        .rob_bits  (rob_bits),
        .cnt_width (cnt_width)
    ) commit_tracer_i (
        .clk       (clk),
        .rst       (rst),
        .dec_valid (dec_valid),
        .dec_opid  (dec_opid),
        .csr_now   (csr_now),
        .cmt_in    (cmt_in),
        .csr_wr    (csr_wr),
        .st_req    (st_req),
        .st_resp   (st_resp),
        .pmd       (pmd),
        .cmt_out   (cmt_out),
        .csr_out   (csr_out),
        .mem_out   (mem_out),
        .counts    (counts)
    );

    bind commit_tracer commit_tracer_checker #(
        .rob_bits  (rob_bits),
        .cnt_width (cnt_width)
    ) chk_i (
        .clk       (clk),
        .rst       (rst),
        .dec_valid (dec_valid),
        .dec_opid  (dec_opid),
        .csr_now   (csr_now),
        .cmt_in    (cmt_in),
        .csr_wr    (csr_wr),
        .st_req    (st_req),
        .st_resp   (st_resp),
        .pmd       (pmd),
        .cmt_out   (cmt_out),
        .csr_out   (csr_out),
        .mem_out   (mem_out),
        .counts    (counts)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [xlen-1:0] rand64();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic logic report_seen(input int which);
        case (which)
            0:       return cmt_out.valid;
            1:       return csr_out.we;
            default: return mem_out.size != 4'd0;
        endcase
    endfunction

    // polls the chosen report strobe on falling edges
    task automatic wait_report(input int which, input string name);
        int n;
        n = 0;
        @(negedge clk);
        while (!report_seen(which) && n < 10) begin
            @(negedge clk);
            n++;
        end
        if (!report_seen(which)) begin
            timeouts++;
            $display("timeout: no report appeared after the %s", name);
        end
    endtask

    task automatic finish_test(input string name);
        tests_done++;
        $display("test %0d %s finished, failures so far %0d", tests_done, name,
                 commit_tracer_i.chk_i.err_cnt + timeouts);
    endtask

    task automatic decode_slot(input logic [rob_bits-1:0] opid);
        csr_state_t s;
        s = {rand64(), rand64(), rand64(), rand64(), rand64(), rand64()};
        @(posedge clk);
        dec_valid <= 1'b1;
        dec_opid  <= opid;
        csr_now   <= s;
    endtask

    task automatic send_commit(input logic [rob_bits-1:0] opid, input logic [4:0] rd,
                               input logic exc);
        commit_t c;
        c = '0;
        c.valid    = 1'b1;
        c.opid     = 8'(opid);
        c.pc       = rand64();
        c.ir       = $random(seed);
        c.rd       = rd;
        c.rd_value = rand64();
        c.exc      = exc;
        c.ret      = 1'($random(seed));
        @(posedge clk);
        cmt_in <= c;
        @(posedge clk);
        cmt_in.valid <= 1'b0;
        wait_report(0, "commit");
    endtask

    task automatic send_csr(input logic [11:0] addr);
        csr_write_t w;
        w.we    = 1'b1;
        w.addr  = addr;
        w.value = rand64();
        @(posedge clk);
        csr_wr <= w;
        @(posedge clk);
        csr_wr.we <= 1'b0;
        wait_report(1, "csr write");
    endtask

    task automatic send_store(input logic [7:0] strb, input logic miss);
        store_req_t  r;
        store_resp_t p;
        r.valid = 1'b1;
        r.tag   = 4'($random(seed));
        r.addr  = rand64();
        r.data  = rand64();
        r.strb  = strb;
        p.valid = 1'b1;
        p.tag   = r.tag;
        p.miss  = miss;
        @(posedge clk);
        st_req <= r;
        @(posedge clk);
        st_req.valid <= 1'b0;
        st_resp      <= p;
        @(posedge clk);
        st_resp.valid <= 1'b0;
        if (!miss) begin
            wait_report(2, "store hit response");
        end else begin
            repeat (2) @(negedge clk); // size 0 is due one cycle after the miss
        end
    endtask

    initial begin
        rst       = 1'b1;
        dec_valid = 1'b0;
        dec_opid  = '0;
        csr_now   = '0;
        cmt_in    = '0;
        csr_wr    = '0;
        st_req    = '0;
        st_resp   = '0;
        pmd       = '0;
        opids     = '{7'd3, 7'd17, 7'd64, 7'd100, 7'd127};
        csr_list  = '{sstatus, sie, sip, cycle, csr_time, instret, 12'h700};
        csr_list[6] = 12'h700 + {4'h0, 8'($random(seed))}; // outside every alias range
        strb_list = '{8'h01, 8'h80, 8'h0c, 8'h30, 8'hff, 8'h0f};

        repeat (16) @(posedge clk);
        rst <= 1'b0;
        repeat (2) @(negedge clk);
        finish_test("reset values");

        for (int i = 0; i < 5; i++) begin
            decode_slot(opids[i]);
        end
        @(posedge clk);
        dec_valid <= 1'b0;
        for (int i = 4; i >= 0; i--) begin
            send_commit(opids[i], (i == 0) ? 5'd0 : 5'(i * 6 + 1), i == 2); // x0, trap, normal
        end
        finish_test("commit snapshots");

        for (int i = 0; i < 7; i++) begin
            send_csr(csr_list[i]);
        end
        finish_test("csr normalization");

        for (int i = 0; i < 6; i++) begin
            send_store(strb_list[i], 1'b0);
        end
        finish_test("store hits");

        send_store(8'h0f, 1'b1);
        send_store(8'hff, 1'b1);
        finish_test("store misses");

        for (int i = 0; i < 200; i++) begin
            @(posedge clk);
            pmd <= num_events'($random(seed));
        end
        @(posedge clk);
        pmd <= '0;
        repeat (2) @(negedge clk);
        finish_test("event counters");

        errors = commit_tracer_i.chk_i.err_cnt + timeouts;
        $display("tests %0d, assertion failures %0d, timeouts %0d", tests_done,
                 commit_tracer_i.chk_i.err_cnt, timeouts);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* bench/commit_tracer_checker.sv */
// concurrent checks on the commit tracer outputs, bound into the top level by the testbench
`timescale 1ns/10ps

module commit_tracer_checker
    import trace_pkg::*;
#(
    parameter int rob_bits  = 7,
    parameter int cnt_width = 32
) (
    input logic                                  clk,
    input logic                                  rst,
    input logic                                  dec_valid,
    input logic [rob_bits-1:0]                   dec_opid,
    input csr_state_t                            csr_now,
    input commit_t                               cmt_in,
    input csr_write_t                            csr_wr,
    input store_req_t                            st_req,
    input store_resp_t                           st_resp,
    input logic [num_events-1:0]                 pmd,
    input commit_out_t                           cmt_out,
    input csr_write_t                            csr_out,
    input mem_out_t                              mem_out,
    input logic [num_events-1:0][cnt_width-1:0] counts
);

    int err_cnt = 0; // read by the testbench summary

    csr_state_t      snap_tab [2 ** rob_bits];
    logic [xlen-1:0] st_addr_tab [16];
    logic [xlen-1:0] st_data_tab [16];
    logic [3:0]      st_size_tab [16];

    logic [num_events-1:0][cnt_width-1:0] exp_cnt;

    csr_state_t      exp_csr;
    logic [11:0]     exp_addr;
    logic [3:0]      req_size;
    logic [2:0]      req_low;
    logic            req_found;
    logic [xlen-1:0] req_data;

    always_comb begin
        exp_csr = snap_tab[cmt_in.opid[rob_bits-1:0]];
        case (csr_wr.addr)
            sstatus, sie, sip:        exp_addr = csr_wr.addr + 12'h200; // supervisor alias
            cycle, csr_time, instret: exp_addr = csr_wr.addr - 12'h100; // counter alias
            default:                  exp_addr = csr_wr.addr;
        endcase
    end

    always_comb begin
        req_size  = 4'd0;
        req_low   = 3'd0;
        req_found = 1'b0;
        for (int b = 0; b < 8; b++) begin
            if (st_req.strb[b]) begin
                req_size = req_size + 4'd1;
                if (!req_found) begin
                    req_low   = 3'(b);
                    req_found = 1'b1;
                end
            end
        end
        req_data = st_req.data >> {req_low, 3'b000}; // lowest written byte to bit 0
    end

    always_ff @(posedge clk) begin
        if (dec_valid) begin
            snap_tab[dec_opid] <= csr_now;
        end
        if (st_req.valid) begin
            st_addr_tab[st_req.tag] <= st_req.addr;
            st_data_tab[st_req.tag] <= req_data;
            st_size_tab[st_req.tag] <= req_size;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            exp_cnt <= '0;
        end else begin
            for (int i = 0; i < num_events; i++) begin
                if (pmd[i]) begin
                    exp_cnt[i] <= exp_cnt[i] + cnt_width'(1);
                end
            end
        end
    end

    a_reset: assert property (@(posedge clk)
        rst |=> !cmt_out.valid && !csr_out.we && mem_out.size == 4'd0 && counts == '0)
        else begin
            err_cnt = err_cnt + 1;
            $error("ERR %0t outputs not cleared by reset", $time);
        end

    a_valid: assert property (@(posedge clk) disable iff (rst)
        cmt_out.valid == $past(cmt_in.valid) && csr_out.we == $past(csr_wr.we))
        else begin
            err_cnt = err_cnt + 1;
            $error("ERR %0t report strobe not one cycle after its input", $time);
        end

    a_commit: assert property (@(posedge clk) disable iff (rst)
        cmt_in.valid |=> cmt_out.pc == $past(cmt_in.pc) && cmt_out.ir == $past(cmt_in.ir)
            && cmt_out.rd == $past(cmt_in.rd) && cmt_out.rd_value == $past(cmt_in.rd_value)
            && cmt_out.exc == $past(cmt_in.exc) && cmt_out.ret == $past(cmt_in.ret)
            && cmt_out.gpr_write == ($past(cmt_in.rd) != 5'd0 && !$past(cmt_in.exc))
            && cmt_out.csr == $past(exp_csr))
        else begin
            err_cnt = err_cnt + 1;
            $error("ERR %0t commit report mismatch at pc %0h", $time, cmt_out.pc);
        end

    a_csr: assert property (@(posedge clk) disable iff (rst)
        csr_wr.we |=> csr_out.addr == $past(exp_addr) && csr_out.value == $past(csr_wr.value))
        else begin
            err_cnt = err_cnt + 1;
            $error("ERR %0t csr write report mismatch, addr %0h", $time, csr_out.addr);
        end

    a_store_hit: assert property (@(posedge clk) disable iff (rst)
        st_resp.valid && !st_resp.miss |=> mem_out.size == $past(st_size_tab[st_resp.tag])
            && mem_out.addr == $past(st_addr_tab[st_resp.tag])
            && mem_out.data == $past(st_data_tab[st_resp.tag]))
        else begin
            err_cnt = err_cnt + 1;
            $error("ERR %0t store report mismatch, addr %0h", $time, mem_out.addr);
        end

    a_store_none: assert property (@(posedge clk) disable iff (rst)
        !(st_resp.valid && !st_resp.miss) |=> mem_out.size == 4'd0)
        else begin
            err_cnt = err_cnt + 1;
            $error("ERR %0t store report without a hit response", $time);
        end

    a_counts: assert property (@(posedge clk) disable iff (rst) counts == exp_cnt)
        else begin
            err_cnt = err_cnt + 1;
            $error("ERR %0t event counters differ from pulse count", $time);
        end

endmodule

/* logic/commit_tracer.sv */
// top level of the commit tracer, links the decode, execute and result stages with the counters
`timescale 1ns/10ps

module commit_tracer
    import trace_pkg::*;
#(
    parameter int rob_bits  = 7,
    parameter int cnt_width = 32
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  dec_valid,
    input  logic [rob_bits-1:0]                   dec_opid,
    input  csr_state_t                            csr_now,
    input  commit_t                               cmt_in,
    input  csr_write_t                            csr_wr,
    input  store_req_t                            st_req,
    input  store_resp_t                           st_resp,
    input  logic [num_events-1:0]                 pmd,
    output commit_out_t                           cmt_out,
    output csr_write_t                            csr_out,
    output mem_out_t                              mem_out,
    output logic [num_events-1:0][cnt_width-1:0] counts
);

    csr_state_t prior_csr; // snapshot of the committing slot

    csr_snapshot #(
        .rob_bits (rob_bits)
    ) csr_snapshot_i (
        .clk       (clk),
        .dec_valid (dec_valid),
        .dec_opid  (dec_opid),
        .csr_now   (csr_now),
        .rd_opid   (cmt_in.opid[rob_bits-1:0]),
        .prior_csr (prior_csr)
    );

    store_tracker store_tracker_i (
        .clk     (clk),
        .rst     (rst),
        .st_req  (st_req),
        .st_resp (st_resp),
        .mem_out (mem_out)
    );

    commit_report commit_report_i (
        .clk       (clk),
        .rst       (rst),
        .cmt_in    (cmt_in),
        .prior_csr (prior_csr),
        .csr_wr    (csr_wr),
        .cmt_out   (cmt_out),
        .csr_out   (csr_out)
    );

    perf_counters #(
        .cnt_width (cnt_width)
    ) perf_counters_i (
        .clk    (clk),
        .rst    (rst),
        .pmd    (pmd),
        .counts (counts)
    );

endmodule

/* logic/perf_counters.sv */
// event counters of the tracer, one per performance event pulse line
`timescale 1ns/10ps

module perf_counters
    import trace_pkg::*;
#(
    parameter int cnt_width = 32
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic [num_events-1:0]                 pmd,
    output logic [num_events-1:0][cnt_width-1:0] counts
);

    // index follows perf_event_e, counters wrap at cnt_width
    always_ff @(posedge clk) begin
        if (rst) begin
            counts <= '0;
        end else begin
            for (int i = 0; i < num_events; i++) begin
                counts[i] <= counts[i] + cnt_width'(pmd[i]);
            end
        end
    end

endmodule

/* logic/commit_report.sv */
// result stage of the tracer, registers the commit record and the normalized CSR write
`timescale 1ns/10ps

module commit_report
    import trace_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  commit_t     cmt_in,
    input  csr_state_t  prior_csr,
    input  csr_write_t  csr_wr,
    output commit_out_t cmt_out,
    output csr_write_t  csr_out
);

    // supervisor aliases map to machine CSRs, user counters to machine counters
    function automatic logic [11:0] norm_addr(input logic [11:0] addr);
        case (addr)
            sstatus, sie, sip:         return addr + 12'h200;
            cycle, csr_time, instret:  return addr - 12'h100;
            default:                   return addr;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            cmt_out.valid <= 1'b0;
        end else begin
            cmt_out.valid <= cmt_in.valid;
        end
    end

    always_ff @(posedge clk) begin
        cmt_out.pc        <= cmt_in.pc;
        cmt_out.ir        <= cmt_in.ir;
        cmt_out.gpr_write <= (cmt_in.rd != 5'd0) && !cmt_in.exc; // x0 and traps write nothing
        cmt_out.rd        <= cmt_in.rd;
        cmt_out.rd_value  <= cmt_in.rd_value;
        cmt_out.exc       <= cmt_in.exc;
        cmt_out.ret       <= cmt_in.ret;
        cmt_out.csr       <= prior_csr;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            csr_out.we <= 1'b0;
        end else begin
            csr_out.we <= csr_wr.we;
        end
    end

    always_ff @(posedge clk) begin
        csr_out.addr  <= norm_addr(csr_wr.addr);
        csr_out.value <= csr_wr.value;
    end

endmodule

/* logic/store_tracker.sv */
// execute stage of the tracer that remembers store requests by tag and reports them on a hit
`timescale 1ns/10ps

module store_tracker
    import trace_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  store_req_t  st_req,
    input  store_resp_t st_resp,
    output mem_out_t    mem_out
);

    localparam int depth = 16; // one entry per tag value

    logic [xlen-1:0] addr_mem [depth];
    logic [xlen-1:0] data_mem [depth];
    logic [3:0]      size_mem [depth];

    logic [2:0]      low_byte; // lowest set strobe lane
    logic [3:0]      byte_cnt;
    logic [xlen-1:0] aligned;

    always_comb begin
        low_byte = 3'd0;
        for (int i = 7; i >= 0; i--) begin
            if (st_req.strb[i]) begin
                low_byte = 3'(i);
            end
        end
        byte_cnt = 4'($countones(st_req.strb));
        aligned  = st_req.data >> (8 * low_byte); // move written bytes to bit 0
    end

    always_ff @(posedge clk) begin
        if (st_req.valid) begin
            addr_mem[st_req.tag] <= st_req.addr;
            data_mem[st_req.tag] <= aligned;
            size_mem[st_req.tag] <= byte_cnt;
        end
    end

    // nonzero size marks a reported write
    always_ff @(posedge clk) begin
        if (rst) begin
            mem_out.size <= 4'd0;
        end else if (st_resp.valid && !st_resp.miss) begin
            mem_out.size <= size_mem[st_resp.tag];
        end else begin
            mem_out.size <= 4'd0; // miss or idle
        end
    end

    always_ff @(posedge clk) begin
        mem_out.addr <= addr_mem[st_resp.tag];
        mem_out.data <= data_mem[st_resp.tag];
    end

endmodule

/* logic/csr_snapshot.sv */
// decode stage of the tracer that keeps the CSR state seen at decode for every ROB slot
`timescale 1ns/10ps

module csr_snapshot
    import trace_pkg::*;
#(
    parameter int rob_bits = 7
) (
    input  logic                clk,
    input  logic                dec_valid,
    input  logic [rob_bits-1:0] dec_opid,
    input  csr_state_t          csr_now,
    input  logic [rob_bits-1:0] rd_opid,
    output csr_state_t          prior_csr
);

    localparam int slots = 2 ** rob_bits;

    csr_state_t snap_mem [slots]; // one snapshot per rob slot

    // written on the decode strobe
    always_ff @(posedge clk) begin
        if (dec_valid) begin
            snap_mem[dec_opid] <= csr_now;
        end
    end

    // committing slot reads its own snapshot in the same cycle
    always_comb begin
        prior_csr = snap_mem[rd_opid];
    end

endmodule

/* logic/trace_pkg.sv */
// shared widths, record structs and encodings for the commit tracer and its testbench
package trace_pkg;

    localparam int xlen = 64; // data and address width

    typedef struct packed {
        logic [xlen-1:0] mstatus;
        logic [xlen-1:0] mtvec;
        logic [xlen-1:0] mcause;
        logic [xlen-1:0] mepc;
        logic [xlen-1:0] mtval;
        logic [xlen-1:0] mip;
    } csr_state_t;

    typedef struct packed {
        logic            valid;
        logic [7:0]      opid;     // rob slot, low rob_bits used
        logic [xlen-1:0] pc;
        logic [31:0]     ir;
        logic [4:0]      rd;
        logic [xlen-1:0] rd_value;
        logic            exc;      // took an exception
        logic            ret;      // return from exception
    } commit_t;

    typedef struct packed {
        logic            we;
        logic [11:0]     addr;
        logic [xlen-1:0] value;
    } csr_write_t;

    typedef struct packed {
        logic            valid;
        logic [3:0]      tag;
        logic [xlen-1:0] addr;
        logic [xlen-1:0] data;
        logic [7:0]      strb;
    } store_req_t;

    typedef struct packed {
        logic       valid;
        logic [3:0] tag;
        logic       miss;
    } store_resp_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [31:0]     ir;
        logic            gpr_write;
        logic [4:0]      rd;
        logic [xlen-1:0] rd_value;
        logic            exc;
        logic            ret;
        csr_state_t      csr;       // state before the instruction ran
    } commit_out_t;

    typedef struct packed {
        logic [3:0]      size;      // bytes written, 0 for none
        logic [xlen-1:0] addr;
        logic [xlen-1:0] data;
    } mem_out_t;

    // time is a keyword, so the user timer CSR is csr_time
    typedef enum logic [11:0] {
        sstatus     = 12'h100,
        sie         = 12'h104,
        sip         = 12'h144,
        mstatus     = 12'h300,
        mie         = 12'h304,
        mip         = 12'h344,
        cycle       = 12'hC00,
        csr_time    = 12'hC01,
        instret     = 12'hC02,
        mcycle      = 12'hB00,
        mtime_alias = 12'hB01,
        minstret    = 12'hB02
    } csr_addr_e;

    typedef enum logic [2:0] {
        ev_load,
        ev_store,
        ev_itlb,
        ev_dtlb,
        ev_icache,
        ev_dcache,
        ev_stlb
    } perf_event_e;

    localparam int num_events = int'(ev_stlb) + 1; // seven counters

endpackage
